// ==== bpred.f ====
source/bpred_pkg.sv
source/bpred_fetch_if.sv
source/bpred_pc_gen.sv
source/bpred_btb.sv
source/bpred_ras.sv
source/bpred_predict_stage.sv
source/bpred_top.sv
tests/bpred_checker.sv
tests/bpred_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the bpred testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module bpred_tb -f bpred.f --Mdir "$BUILD_DIR" -o bpred_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./"$BUILD_DIR"/bpred_sim > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

// ==== tests/bpred_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module bpred_tb;

  localparam int CLK_PERIOD  = 20;
  localparam int DRIVE_DELAY = 2;
  localparam int NUM_TESTS   = 5;
  // Cycle budgets per test
  localparam int T1_CYCLES = 40;
  localparam int T2_CYCLES = 1000;
  localparam int T3_CYCLES = 200;
  localparam int T4_CYCLES = 1500;
  localparam int T5_CYCLES = 1260;
  localparam int TIMEOUT_CYCLES =
    (T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES) * 11 / 10;
  localparam int T5_REDIRECTS = 100;
  localparam bit [31:0] SEED = 32'h696b_b1bc;
  // Call chain layout, calls at base+8k and returns right after each
  localparam bpred_pkg::addr_t CHAIN_BASE = 32'h0000_2000;
  localparam bpred_pkg::addr_t JAL_PC     = 32'h0000_2030;
  localparam bpred_pkg::addr_t EXIT_PC    = 32'h0000_2040;

  logic                clk;
  logic                rst_n;
  logic                fetch_valid;
  logic                fetch_ready;
  bpred_pkg::addr_t    fetch_pc;
  logic                fetch_taken;
  bpred_pkg::addr_t    fetch_target;
  logic                redirect_en;
  bpred_pkg::addr_t    redirect_pc;
  logic                update_en;
  bpred_pkg::addr_t    update_pc;
  bpred_pkg::addr_t    update_target;
  logic                update_taken;
  bpred_pkg::br_kind_e update_kind;

  int error_count;
  int packet_count;
  int cycle_count;
  int tests_passed;
  int errors_before;

  bpred_top bpred_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_valid   (fetch_valid),
    .fetch_ready   (fetch_ready),
    .fetch_pc      (fetch_pc),
    .fetch_taken   (fetch_taken),
    .fetch_target  (fetch_target),
    .redirect_en   (redirect_en),
    .redirect_pc   (redirect_pc),
    .update_en     (update_en),
    .update_pc     (update_pc),
    .update_target (update_target),
    .update_taken  (update_taken),
    .update_kind   (update_kind)
  );

  bpred_checker checker_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_valid   (fetch_valid),
    .fetch_ready   (fetch_ready),
    .fetch_pc      (fetch_pc),
    .fetch_taken   (fetch_taken),
    .fetch_target  (fetch_target),
    .redirect_en   (redirect_en),
    .redirect_pc   (redirect_pc),
    .update_en     (update_en),
    .update_pc     (update_pc),
    .update_target (update_target),
    .update_taken  (update_taken),
    .update_kind   (update_kind),
    .error_count   (error_count),
    .packet_count  (packet_count)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
    end
  end

  // Hard stop if the run outlives its budget
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  // Drive point is just after the edge, single-cycle pulses drop here
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
    update_en   = 1'b0;
    redirect_en = 1'b0;
  endtask

  task automatic drive_update(input bpred_pkg::addr_t pc, input bpred_pkg::addr_t target,
                              input logic taken, input bpred_pkg::br_kind_e kind);
    update_en     = 1'b1;
    update_pc     = pc;
    update_target = target;
    update_taken  = taken;
    update_kind   = kind;
  endtask

  task automatic wait_packets(input int count);
    int goal;
    goal = packet_count + count;
    while (packet_count < goal) begin
      next_cycle();
    end
  endtask

  // Any word in the 256 byte region at 0x1000
  function automatic bpred_pkg::addr_t region_pc();
    return 32'h0000_1000 + 32'($urandom_range(63, 0)) * 32'd4;
  endfunction

  // Four tags sharing indexes 0 to 3
  function automatic bpred_pkg::addr_t collide_pc();
    return 32'h0000_1000 + 32'($urandom_range(3, 0)) * 32'h40 +
           32'($urandom_range(3, 0)) * 32'd4;
  endfunction

  task automatic report_test(input int num, input string name);
    int new_errors;
    new_errors = error_count - errors_before;
    if (new_errors == 0) begin
      tests_passed++;
      $display("Test %0d %s: PASS", num, name);
    end else begin
      $display("Test %0d %s: FAIL with %0d errors", num, name, new_errors);
    end
    errors_before = error_count;
  endtask

  initial begin
    int gap;
    rst_n         = 1'b0;
    fetch_ready   = 1'b1;
    redirect_en   = 1'b0;
    redirect_pc   = '0;
    update_en     = 1'b0;
    update_pc     = '0;
    update_target = '0;
    update_taken  = 1'b0;
    update_kind   = bpred_pkg::KIND_BRANCH;
    tests_passed  = 0;
    errors_before = 0;
    void'($urandom(SEED));

    // Test 1, boot address then plain sequential fetch
    repeat (3) next_cycle();
    rst_n = 1'b1;
    wait_packets(20);
    report_test(1, "reset and sequential fetch");

    // Test 2, aliasing conditional branches
    for (int i = 0; i < T2_CYCLES; i++) begin
      next_cycle();
      if (i % 24 == 0) begin
        // Pull fetch back into the trained region
        redirect_en = 1'b1;
        redirect_pc = region_pc();
      end else if ($urandom_range(2, 0) == 0) begin
        drive_update(collide_pc(), region_pc(), 1'($urandom_range(1, 0)),
                     bpred_pkg::KIND_BRANCH);
      end
    end
    report_test(2, "branch counter and tag training");

    // Test 3, six nested calls overflow the four deep stack
    for (int k = 0; k < 6; k++) begin
      next_cycle();
      drive_update(CHAIN_BASE + 32'(8 * k),
                   (k < 5) ? CHAIN_BASE + 32'(8 * k + 8) : CHAIN_BASE + 32'(8 * k + 4),
                   1'b1, bpred_pkg::KIND_CALL);
    end
    for (int k = 0; k < 6; k++) begin
      next_cycle();
      drive_update(CHAIN_BASE + 32'(8 * k + 4), EXIT_PC, 1'b1, bpred_pkg::KIND_RET);
    end
    next_cycle();
    drive_update(JAL_PC, CHAIN_BASE, 1'b1, bpred_pkg::KIND_JAL);
    next_cycle();
    redirect_en = 1'b1;
    redirect_pc = JAL_PC;
    repeat (40) next_cycle();
    // Same chain again under random stalls
    redirect_en = 1'b1;
    redirect_pc = JAL_PC;
    for (int i = 0; i < 80; i++) begin
      next_cycle();
      fetch_ready = 1'($urandom_range(1, 0));
    end
    fetch_ready = 1'b1;
    report_test(3, "jal, call and return stack");

    // Test 4, random back-pressure with mixed training
    for (int i = 0; i < T4_CYCLES; i++) begin
      next_cycle();
      fetch_ready = 1'($urandom_range(1, 0));
      if ($urandom_range(39, 0) == 0) begin
        redirect_en = 1'b1;
        redirect_pc = region_pc();
      end else if ($urandom_range(3, 0) == 0) begin
        drive_update(collide_pc(), region_pc(), 1'($urandom_range(1, 0)),
                     bpred_pkg::br_kind_e'(2'($urandom_range(3, 0))));
      end
    end
    next_cycle();
    fetch_ready = 1'b1;
    report_test(4, "back-pressure");

    // Test 5, redirects anywhere, checker enforces the 2 cycle restart
    for (int n = 0; n < T5_REDIRECTS; n++) begin
      gap = $urandom_range(7, 0);
      repeat (gap) next_cycle();
      next_cycle();
      redirect_en = 1'b1;
      if ($urandom_range(1, 0) == 0) begin
        redirect_pc = region_pc();
      end else begin
        redirect_pc = 32'($urandom) & 32'hffff_fffc;
      end
      next_cycle();
      wait_packets(1);
    end
    report_test(5, "redirect restart");

    $display("Summary: %0d of %0d tests clean, %0d packets, %0d errors",
             tests_passed, NUM_TESTS, packet_count, error_count);
    if (error_count == 0 && tests_passed == NUM_TESTS) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/bpred_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module bpred_checker (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                fetch_valid,
  input  wire logic                fetch_ready,
  input  wire bpred_pkg::addr_t    fetch_pc,
  input  wire logic                fetch_taken,
  input  wire bpred_pkg::addr_t    fetch_target,
  input  wire logic                redirect_en,
  input  wire bpred_pkg::addr_t    redirect_pc,
  input  wire logic                update_en,
  input  wire bpred_pkg::addr_t    update_pc,
  input  wire bpred_pkg::addr_t    update_target,
  input  wire logic                update_taken,
  input  wire bpred_pkg::br_kind_e update_kind,
  output int                       error_count,
  output int                       packet_count
);

  // Buffer model
  logic                m_valid  [bpred_pkg::BTB_ENTRIES];
  bpred_pkg::btb_tag_t m_tag    [bpred_pkg::BTB_ENTRIES];
  bpred_pkg::addr_t    m_target [bpred_pkg::BTB_ENTRIES];
  bpred_pkg::ctr_t     m_ctr    [bpred_pkg::BTB_ENTRIES];
  bpred_pkg::br_kind_e m_kind   [bpred_pkg::BTB_ENTRIES];

  // Stack model, newest at the back
  bpred_pkg::addr_t ras_q [$];
  // Expected packets as {taken, pc, target}
  logic [64:0]      exp_q [$];
  bpred_pkg::addr_t m_pc;
  // Mirrors the PC stage request bit
  logic             m_gen_valid;
  int               errors = 0;
  int               packets = 0;

  assign error_count  = errors;
  assign packet_count = packets;

  function automatic int index_of(input bpred_pkg::addr_t pc);
    return int'(pc[bpred_pkg::INDEX_BITS+1:2]);
  endfunction

  function automatic bpred_pkg::btb_tag_t tag_of(input bpred_pkg::addr_t pc);
    return pc[bpred_pkg::XLEN-1:bpred_pkg::XLEN-bpred_pkg::TAG_BITS];
  endfunction

  // Counter and entry training for one resolved branch
  task automatic train_model();
    int   idx;
    logic fresh;
    idx   = index_of(update_pc);
    fresh = !m_valid[idx] || (m_tag[idx] != tag_of(update_pc));
    if (update_kind != bpred_pkg::KIND_BRANCH) begin
      m_ctr[idx] = 2'd3;
    end else if (fresh) begin
      m_ctr[idx] = update_taken ? 2'd2 : 2'd1;
    end else if (update_taken && m_ctr[idx] != 2'd3) begin
      m_ctr[idx] = m_ctr[idx] + 2'd1;
    end else if (!update_taken && m_ctr[idx] != 2'd0) begin
      m_ctr[idx] = m_ctr[idx] - 2'd1;
    end
    m_valid[idx]  = 1'b1;
    m_tag[idx]    = tag_of(update_pc);
    m_target[idx] = update_target;
    m_kind[idx]   = update_kind;
  endtask

  // Prediction for the model PC, queued as the next expected packet
  task automatic predict_and_capture();
    int               idx;
    logic             hit;
    logic             taken;
    bpred_pkg::addr_t target;
    idx    = index_of(m_pc);
    hit    = m_valid[idx] && (m_tag[idx] == tag_of(m_pc));
    taken  = 1'b0;
    target = '0;
    if (hit) begin
      target = m_target[idx];
      case (m_kind[idx])
        bpred_pkg::KIND_RET: begin
          taken = 1'b1;
          // Empty stack keeps the stored target
          if (ras_q.size() > 0) begin
            target = ras_q.pop_back();
          end
        end
        bpred_pkg::KIND_CALL: begin
          taken = 1'b1;
          ras_q.push_back(m_pc + 32'd4);
          // Oldest return address drops out
          if (ras_q.size() > bpred_pkg::RAS_DEPTH) begin
            void'(ras_q.pop_front());
          end
        end
        bpred_pkg::KIND_JAL: taken = 1'b1;
        default: taken = m_ctr[idx][1];
      endcase
    end
    exp_q.push_back({taken, m_pc, target});
    m_pc = taken ? target : m_pc + 32'd4;
  endtask

  // Output side, looked at with the values just before the edge
  task automatic check_output();
    logic [64:0] exp;
    if (fetch_valid && exp_q.size() == 0) begin
      errors++;
      $display("Unexpected packet for pc %h at %0d ns with nothing pending", fetch_pc, $time);
    end else if (fetch_valid) begin
      exp = exp_q[0];
      // Also catches a packet that moves while stalled
      if (fetch_pc !== exp[63:32] || fetch_taken !== exp[64] || fetch_target !== exp[31:0]) begin
        errors++;
        $display("FAIL at %0d ns: got pc %h taken %b target %h", $time,
                 fetch_pc, fetch_taken, fetch_target);
        $display("  expected pc %h taken %b target %h", exp[63:32], exp[64], exp[31:0]);
      end
      if (fetch_ready) begin
        void'(exp_q.pop_front());
      end
    end else if (exp_q.size() != 0) begin
      errors++;
      $display("Packet for pc %h never showed up, at %0d ns", exp_q[0][63:32], $time);
    end
    if (fetch_valid && fetch_ready) begin
      packets++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < bpred_pkg::BTB_ENTRIES; i++) begin
        m_valid[i] = 1'b0;
      end
      ras_q.delete();
      exp_q.delete();
      m_gen_valid = 1'b0;
    end else begin
      check_output();
      // Capture edge rebuilt from the ports
      if (m_gen_valid && !redirect_en && (!fetch_valid || fetch_ready)) begin
        predict_and_capture();
      end
      if (redirect_en) begin
        exp_q.delete();
        m_pc = redirect_pc;
      end else if (!m_gen_valid) begin
        m_pc = bpred_pkg::RESET_PC;
      end
      m_gen_valid = 1'b1;
      // Training lands after the lookup of this cycle
      if (update_en) begin
        train_model();
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/bpred_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module bpred_top (
  input  wire logic                clk,
  input  wire logic                rst_n,
  // Fetch packet out
  output logic                     fetch_valid,
  input  wire logic                fetch_ready,
  output bpred_pkg::addr_t         fetch_pc,
  output logic                     fetch_taken,
  output bpred_pkg::addr_t         fetch_target,
  // Fetch restart from execute
  input  wire logic                redirect_en,
  input  wire bpred_pkg::addr_t    redirect_pc,
  // Branch resolution training
  input  wire logic                update_en,
  input  wire bpred_pkg::addr_t    update_pc,
  input  wire bpred_pkg::addr_t    update_target,
  input  wire logic                update_taken,
  input  wire bpred_pkg::br_kind_e update_kind
);

  // Stage 1 to stage 2 request and next PC feedback
  bpred_fetch_if fetch_if ();

  bpred_pc_gen pc_gen_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .req         (fetch_if.gen)
  );

  bpred_predict_stage predict_stage_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_en   (redirect_en),
    .fetch_ready   (fetch_ready),
    .req           (fetch_if.pred),
    .fetch_valid   (fetch_valid),
    .fetch_taken   (fetch_taken),
    .fetch_pc      (fetch_pc),
    .fetch_target  (fetch_target),
    .update_en     (update_en),
    .update_taken  (update_taken),
    .update_pc     (update_pc),
    .update_target (update_target),
    .update_kind   (update_kind)
  );

endmodule

`default_nettype wire

// ==== source/bpred_predict_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module bpred_predict_stage (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                redirect_en,
  input  wire logic                fetch_ready,
  bpred_fetch_if.pred              req,
  output logic                     fetch_valid,
  output logic                     fetch_taken,
  output bpred_pkg::addr_t         fetch_pc,
  output bpred_pkg::addr_t         fetch_target,
  input  wire logic                update_en,
  input  wire logic                update_taken,
  input  wire bpred_pkg::addr_t    update_pc,
  input  wire bpred_pkg::addr_t    update_target,
  input  wire bpred_pkg::br_kind_e update_kind
);

  logic                btb_hit;
  logic                btb_taken;
  bpred_pkg::addr_t    btb_target;
  bpred_pkg::br_kind_e btb_kind;
  bpred_pkg::addr_t    ras_top;
  logic                ras_empty;
  logic                ras_push;
  logic                ras_pop;

  logic                handshake;
  logic                is_call;
  logic                use_ras;
  logic                taken;
  bpred_pkg::addr_t    target;
  bpred_pkg::addr_t    pc_plus4;

  logic                out_valid_q;
  logic                out_taken_q;
  bpred_pkg::addr_t    out_pc_q;
  bpred_pkg::addr_t    out_target_q;

  bpred_btb btb_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookup_pc     (req.pc),
    .hit           (btb_hit),
    .pred_taken    (btb_taken),
    .pred_target   (btb_target),
    .pred_kind     (btb_kind),
    .update_en     (update_en),
    .update_taken  (update_taken),
    .update_pc     (update_pc),
    .update_target (update_target),
    .update_kind   (update_kind)
  );

  bpred_ras ras_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (ras_push),
    .pop       (ras_pop),
    .push_addr (pc_plus4),
    .top_addr  (ras_top),
    .empty     (ras_empty)
  );

  // Stall while the packet is stuck, drop the request during a redirect
  assign req.ready = (!out_valid_q || fetch_ready) && !redirect_en;
  assign handshake = req.valid && req.ready;

  assign pc_plus4 = req.pc + 32'd4;
  assign is_call  = btb_hit && (btb_kind == bpred_pkg::KIND_CALL);
  assign use_ras  = btb_hit && (btb_kind == bpred_pkg::KIND_RET) && !ras_empty;

  // Only conditional branches consult the counter
  // A return with an empty stack falls back to the stored target
  assign taken  = btb_hit && ((btb_kind != bpred_pkg::KIND_BRANCH) || btb_taken);
  assign target = use_ras ? ras_top : btb_target;

  assign req.next_pc = taken ? target : pc_plus4;

  // Stack moves only when the packet is really captured
  assign ras_push = handshake && is_call;
  assign ras_pop  = handshake && use_ras;

  always_ff @(posedge clk) begin
    if (!rst_n || redirect_en) begin
      out_valid_q <= 1'b0;
    end else if (handshake) begin
      out_valid_q <= 1'b1;
    end else if (fetch_ready) begin
      out_valid_q <= 1'b0;
    end
  end

  // Capture edge for the packet payload
  always_ff @(posedge clk) begin
    if (handshake) begin
      out_pc_q     <= req.pc;
      out_taken_q  <= taken;
      out_target_q <= target;
    end
  end

  assign fetch_valid  = out_valid_q;
  assign fetch_pc     = out_pc_q;
  assign fetch_taken  = out_taken_q;
  assign fetch_target = out_target_q;

  // Stalled packet stays put until the consumer takes it
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (fetch_valid && !fetch_ready && !redirect_en) |=>
      (fetch_valid && $stable(fetch_pc) && $stable(fetch_taken) && $stable(fetch_target)));

endmodule

`default_nettype wire

// ==== source/bpred_ras.sv ====
`timescale 1ns/100ps
`default_nettype none

module bpred_ras (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             push,
  input  wire logic             pop,
  input  wire bpred_pkg::addr_t push_addr,
  output bpred_pkg::addr_t      top_addr,
  output logic                  empty
);

  bpred_pkg::addr_t    stack_q [bpred_pkg::RAS_DEPTH];
  // Points at the next free slot, wraps around the ring
  bpred_pkg::ras_ptr_t sp_q;
  bpred_pkg::ras_ptr_t top_ptr;
  // Needs one more value than the depth so full and empty differ
  logic [$clog2(bpred_pkg::RAS_DEPTH+1)-1:0] count_q;

  assign top_ptr  = sp_q - 2'd1;
  assign top_addr = stack_q[top_ptr];
  assign empty    = (count_q == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sp_q    <= '0;
      count_q <= '0;
    end else if (push) begin
      sp_q <= sp_q + 2'd1;
      // Overflow overwrites the oldest slot, count pins at depth
      if (count_q != bpred_pkg::RAS_DEPTH) begin
        count_q <= count_q + 1'b1;
      end
    end else if (pop && !empty) begin
      sp_q    <= top_ptr;
      count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      stack_q[sp_q] <= push_addr;
    end
  end

  // The prediction stage decodes one kind per packet
  a_no_push_pop: assert property (@(posedge clk) disable iff (!rst_n)
    !(push && pop));

endmodule

`default_nettype wire

// ==== source/bpred_btb.sv ====
`timescale 1ns/100ps
`default_nettype none

module bpred_btb (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire bpred_pkg::addr_t    lookup_pc,
  output logic                     hit,
  output logic                     pred_taken,
  output bpred_pkg::addr_t         pred_target,
  output bpred_pkg::br_kind_e      pred_kind,
  input  wire logic                update_en,
  input  wire logic                update_taken,
  input  wire bpred_pkg::addr_t    update_pc,
  input  wire bpred_pkg::addr_t    update_target,
  input  wire bpred_pkg::br_kind_e update_kind
);

  // Entry storage, only the valid bits see reset
  logic [bpred_pkg::BTB_ENTRIES-1:0] valid_q;
  bpred_pkg::btb_tag_t               tag_q    [bpred_pkg::BTB_ENTRIES];
  bpred_pkg::addr_t                  target_q [bpred_pkg::BTB_ENTRIES];
  bpred_pkg::ctr_t                   ctr_q    [bpred_pkg::BTB_ENTRIES];
  bpred_pkg::br_kind_e               kind_q   [bpred_pkg::BTB_ENTRIES];

  bpred_pkg::btb_index_t lookup_index;
  bpred_pkg::btb_tag_t   lookup_tag;
  bpred_pkg::btb_index_t update_index;
  bpred_pkg::btb_tag_t   update_tag;
  bpred_pkg::ctr_t       ctr_old;
  bpred_pkg::ctr_t       ctr_next;
  logic                  entry_fresh;

  // Word aligned, so PC[1:0] never enters index or tag
  assign lookup_index = lookup_pc[bpred_pkg::INDEX_BITS+1:2];
  assign lookup_tag   = lookup_pc[bpred_pkg::XLEN-1:bpred_pkg::XLEN-bpred_pkg::TAG_BITS];
  assign update_index = update_pc[bpred_pkg::INDEX_BITS+1:2];
  assign update_tag   = update_pc[bpred_pkg::XLEN-1:bpred_pkg::XLEN-bpred_pkg::TAG_BITS];

  // Combinational lookup, reads the contents before any same-cycle write
  assign hit = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);

  // Everything reads as zero on a miss
  assign pred_taken  = hit ? ctr_q[lookup_index][1] : 1'b0;
  assign pred_target = hit ? target_q[lookup_index] : '0;
  assign pred_kind   = hit ? kind_q[lookup_index] : bpred_pkg::KIND_BRANCH;

  // Empty slot or a different branch aliasing onto the same index
  assign entry_fresh = !valid_q[update_index] || (tag_q[update_index] != update_tag);
  assign ctr_old     = ctr_q[update_index];

  // Counter training
  always_comb begin
    if (update_kind != bpred_pkg::KIND_BRANCH) begin
      // Jumps, calls and returns are always strongly taken
      ctr_next = 2'd3;
    end else if (entry_fresh) begin
      // Weak state in the resolved direction
      ctr_next = update_taken ? 2'd2 : 2'd1;
    end else if (update_taken) begin
      ctr_next = (ctr_old == 2'd3) ? ctr_old : ctr_old + 2'd1;
    end else begin
      ctr_next = (ctr_old == 2'd0) ? ctr_old : ctr_old - 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (update_en) begin
      valid_q[update_index] <= 1'b1;
    end
  end

  // Payload arrays are guarded by the valid bits
  always_ff @(posedge clk) begin
    if (update_en) begin
      tag_q[update_index]    <= update_tag;
      target_q[update_index] <= update_target;
      ctr_q[update_index]    <= ctr_next;
      kind_q[update_index]   <= update_kind;
    end
  end

  // An X kind would be latched into the entry and poison later predictions
  a_kind_known: assert property (@(posedge clk) disable iff (!rst_n)
    update_en |-> !$isunknown(update_kind));

endmodule

`default_nettype wire

// ==== source/bpred_pc_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module bpred_pc_gen (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             redirect_en,
  input  wire bpred_pkg::addr_t redirect_pc,
  bpred_fetch_if.gen            req
);

  logic             valid_q;
  bpred_pkg::addr_t pc_q;
  logic             handshake;

  assign handshake = valid_q && req.ready;

  // Valid drops only in reset, the stage requests every cycle after it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
    end
  end

  // Next fetch PC select
  always_ff @(posedge clk) begin
    if (redirect_en) begin
      // Redirect wins over the handshake
      pc_q <= redirect_pc;
    end else if (!valid_q) begin
      // First edge out of reset starts at the boot address
      pc_q <= bpred_pkg::RESET_PC;
    end else if (handshake) begin
      pc_q <= req.next_pc;
    end
  end

  assign req.valid = valid_q;
  assign req.pc    = pc_q;

  // PC holds across a stall unless fetch gets redirected
  a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (req.valid && !req.ready && !redirect_en) |=> $stable(req.pc));

endmodule

`default_nettype wire

// ==== source/bpred_fetch_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface bpred_fetch_if;

  // Request side, driven by the PC stage
  logic                valid;
  bpred_pkg::addr_t    pc;

  // Response side, driven by the prediction stage
  logic                ready;
  // Predicted next PC, meaningful whenever valid is high
  bpred_pkg::addr_t    next_pc;

  modport gen (
    output valid,
    output pc,
    input  ready,
    input  next_pc
  );

  modport pred (
    input  valid,
    input  pc,
    output ready,
    output next_pc
  );

endinterface

`default_nettype wire

// ==== source/bpred_pkg.sv ====
`default_nettype none

package bpred_pkg;

  // Address and fetch sizes
  localparam int XLEN = 32;
  localparam bit [XLEN-1:0] RESET_PC = 32'h0000_1000;

  // Direct-mapped target buffer geometry
  localparam int BTB_ENTRIES = 16;
  // Index comes from PC[5:2], tag from PC[31:6]
  localparam int INDEX_BITS = 4;
  localparam int TAG_BITS = 26;

  // Return address stack
  localparam int RAS_DEPTH = 4;

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [INDEX_BITS-1:0] btb_index_t;
  typedef logic [TAG_BITS-1:0] btb_tag_t;
  // 0,1 predict not-taken; 2,3 predict taken
  typedef logic [1:0] ctr_t;
  typedef logic [1:0] ras_ptr_t;

  // Branch kind stored per buffer entry
  typedef enum logic [1:0] {
    KIND_BRANCH = 2'd0,
    KIND_JAL    = 2'd1,
    KIND_CALL   = 2'd2,
    KIND_RET    = 2'd3
  } br_kind_e;

endpackage

`default_nettype wire
